/* fetch_pkg.sv */
package fetch_pkg;

    ////////////////////
    // widths
    ////////////////////
    localparam int PC_W        = 16;
    localparam int INST_W      = 16;
    localparam int OP_W        = 4;
    localparam int BR_OFF_W    = 8;   // signed branch displacement
    localparam int JMP_OFF_W   = 12;  // low pc bits replaced by a jump

    localparam int FETCH_WIDTH = 4;   // slots per bundle
    localparam int MAX_BRANCH  = 2;   // predicted branches per bundle
    localparam int IMEM_DEPTH  = 32;  // rom words, power of two
    localparam int IMEM_AW     = $clog2(IMEM_DEPTH);

    typedef logic [PC_W-1:0]                pc_t;
    typedef logic [INST_W-1:0]              inst_t;
    typedef logic [OP_W-1:0]                op_t;
    typedef logic [$clog2(FETCH_WIDTH)-1:0] slot_t;      // slot index in a bundle
    typedef logic [IMEM_AW-1:0]             imem_idx_t;
    typedef logic [1:0]                     ctr_t;       // msb = predict taken

    ////////////////////
    // opcodes
    ////////////////////
    localparam op_t OP_BRANCH = 4'hB;  // cond branch, pc + 1 + sext(imm8)
    localparam op_t OP_JUMP   = 4'hC;  // imm jump, {pc[15:12], imm12}

    // 2-bit counter states
    localparam ctr_t CTR_STRONG_NT = 2'b00;
    localparam ctr_t CTR_WEAK_NT   = 2'b01;  // reset value
    localparam ctr_t CTR_STRONG_T  = 2'b11;

endpackage

/* instr_mem.sv */
module instr_mem (
    input  fetch_pkg::pc_t   pc,
    output fetch_pkg::inst_t inst0,
    output fetch_pkg::inst_t inst1,
    output fetch_pkg::inst_t inst2,
    output fetch_pkg::inst_t inst3
);
    import fetch_pkg::*;

    inst_t rom [IMEM_DEPTH];
    inst_t rd  [FETCH_WIDTH];  // one read port per slot

    initial begin
        $readmemh("program.hex", rom);
    end

    // truncation to the index width wraps at IMEM_DEPTH
    for (genvar g = 0; g < FETCH_WIDTH; g++) begin : g_rd
        assign rd[g] = rom[imem_idx_t'(pc + pc_t'(g))];
    end

    assign inst0 = rd[0];
    assign inst1 = rd[1];
    assign inst2 = rd[2];
    assign inst3 = rd[3];

endmodule

/* bundle_classifier.sv */
module bundle_classifier (
    input  fetch_pkg::inst_t                    inst0,
    input  fetch_pkg::inst_t                    inst1,
    input  fetch_pkg::inst_t                    inst2,
    input  fetch_pkg::inst_t                    inst3,
    input  logic                                pred0,          // first branch
    input  logic                                pred1,          // second branch
    output logic [fetch_pkg::FETCH_WIDTH-1:0]   is_branch,
    output logic [fetch_pkg::FETCH_WIDTH-1:0]   is_jump,
    output logic [fetch_pkg::FETCH_WIDTH-1:0]   branch_num,     // 0 first, 1 second
    output logic [fetch_pkg::FETCH_WIDTH-1:0]   slot_valid,
    output logic [fetch_pkg::FETCH_WIDTH-1:0]   pred_taken,
    output fetch_pkg::slot_t                    cut_slot,
    output logic                                redirect_taken
);
    import fetch_pkg::*;

    inst_t slot_inst [FETCH_WIDTH];

    assign slot_inst[0] = inst0;
    assign slot_inst[1] = inst1;
    assign slot_inst[2] = inst2;
    assign slot_inst[3] = inst3;

    ////////////////////
    // in-order slot scan
    ////////////////////
    always_comb begin : scan
        logic seen_branch;  // a branch sits in an earlier slot
        logic cut_found;    // bundle already ended
        op_t  op;
        seen_branch    = 1'b0;
        cut_found      = 1'b0;
        cut_slot       = slot_t'(FETCH_WIDTH - 1);  // no transfer: full bundle
        redirect_taken = 1'b0;
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            op            = slot_inst[i][INST_W-1 -: OP_W];
            is_branch[i]  = (op == OP_BRANCH);
            is_jump[i]    = (op == OP_JUMP);
            branch_num[i] = seen_branch;
            slot_valid[i] = !cut_found;     // masked past the cut
            pred_taken[i] = 1'b0;
            if (!cut_found) begin
                if (is_branch[i]) begin
                    pred_taken[i] = seen_branch ? pred1 : pred0;
                    // taken branch or second branch ends it
                    if (pred_taken[i] || seen_branch) begin
                        cut_found      = 1'b1;
                        cut_slot       = slot_t'(i);
                        redirect_taken = pred_taken[i];
                    end
                    seen_branch = 1'b1;
                end else if (is_jump[i]) begin
                    cut_found      = 1'b1;  // jumps always redirect
                    cut_slot       = slot_t'(i);
                    redirect_taken = 1'b1;
                end
            end
        end
    end

endmodule

/* branch_predictor.sv */
module branch_predictor (
    input  logic clk,
    input  logic rst_n,
    input  logic resolve_valid,  // commit strobe
    input  logic resolve_slot,   // which counter to train
    input  logic resolve_taken,
    output logic pred0,
    output logic pred1
);
    import fetch_pkg::*;

    ctr_t ctr [MAX_BRANCH];  // one per branch position in a bundle
    ctr_t cur;

    assign cur = ctr[resolve_slot];

    ////////////////////
    // training
    ////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < MAX_BRANCH; i++) begin
                ctr[i] <= CTR_WEAK_NT;
            end
        end else if (resolve_valid) begin
            if (resolve_taken) begin
                if (cur != CTR_STRONG_T) begin
                    ctr[resolve_slot] <= ctr_t'(cur + 2'd1);  // saturate at 11
                end
            end else if (cur != CTR_STRONG_NT) begin
                ctr[resolve_slot] <= ctr_t'(cur - 2'd1);      // saturate at 00
            end
        end
    end

    // msb means taken
    assign pred0 = ctr[0][1];
    assign pred1 = ctr[1][1];

endmodule

/* target_calc.sv */
module target_calc (
    input  fetch_pkg::pc_t                      pc,
    input  fetch_pkg::inst_t                    inst0,
    input  fetch_pkg::inst_t                    inst1,
    input  fetch_pkg::inst_t                    inst2,
    input  fetch_pkg::inst_t                    inst3,
    input  logic [fetch_pkg::FETCH_WIDTH-1:0]   is_branch,
    input  logic [fetch_pkg::FETCH_WIDTH-1:0]   is_jump,
    input  logic [fetch_pkg::FETCH_WIDTH-1:0]   branch_num,
    input  logic [fetch_pkg::FETCH_WIDTH-1:0]   pred_taken,
    input  fetch_pkg::slot_t                    cut_slot,
    output fetch_pkg::pc_t                      redirect_pc,
    output fetch_pkg::pc_t                      recv_pc0,
    output fetch_pkg::pc_t                      recv_pc1
);
    import fetch_pkg::*;

    inst_t slot_inst [FETCH_WIDTH];
    pc_t   slot_pc   [FETCH_WIDTH];
    pc_t   target    [FETCH_WIDTH];

    assign slot_inst[0] = inst0;
    assign slot_inst[1] = inst1;
    assign slot_inst[2] = inst2;
    assign slot_inst[3] = inst3;

    ////////////////////
    // per-slot targets
    ////////////////////
    for (genvar g = 0; g < FETCH_WIDTH; g++) begin : g_tgt
        assign slot_pc[g] = pc + pc_t'(g);
        assign target[g]  = is_jump[g]
            ? {slot_pc[g][PC_W-1:JMP_OFF_W], slot_inst[g][JMP_OFF_W-1:0]}  // page-local
            : slot_pc[g] + pc_t'(1) + pc_t'($signed(slot_inst[g][BR_OFF_W-1:0]));
    end

    assign redirect_pc = target[cut_slot];  // only used when redirect_taken

    // recovery pc = the path not predicted
    always_comb begin
        recv_pc0 = '0;  // zero when no such branch
        recv_pc1 = '0;
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            if (is_branch[i] && i <= int'(cut_slot)) begin
                if (branch_num[i]) begin
                    recv_pc1 = pred_taken[i] ? slot_pc[i] + pc_t'(1) : target[i];
                end else begin
                    recv_pc0 = pred_taken[i] ? slot_pc[i] + pc_t'(1) : target[i];
                end
            end
        end
    end

endmodule

/* pc_gen.sv */
module pc_gen (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                stall_fetch,     // decode full
    input  logic                has_mispredict,  // rob redirect
    input  fetch_pkg::pc_t      pc_recovery,
    input  logic                exter_pc_en,
    input  fetch_pkg::pc_t      exter_pc,
    input  logic                redirect_taken,
    input  fetch_pkg::pc_t      redirect_pc,
    input  fetch_pkg::slot_t    cut_slot,
    output fetch_pkg::pc_t      pc,
    output logic                fetch_valid
);
    import fetch_pkg::*;

    pc_t  pc_next;
    pc_t  fallthrough;  // slot after the cut
    logic start;        // first edge after reset seen

    assign fallthrough = pc + pc_t'(cut_slot) + pc_t'(1);

    ////////////////////
    // next pc priority
    ////////////////////
    always_comb begin
        if (exter_pc_en) begin
            pc_next = exter_pc;
        end else if (has_mispredict) begin
            pc_next = pc_recovery;
        end else if (stall_fetch || !start) begin
            pc_next = pc;                   // hold, same bundle again
        end else if (redirect_taken) begin
            pc_next = redirect_pc;          // jump or taken branch
        end else begin
            pc_next = fallthrough;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc    <= '0;
            start <= 1'b0;
        end else begin
            pc    <= pc_next;
            start <= 1'b1;
        end
    end

    // any override or stall kills the bundle
    assign fetch_valid = start & ~stall_fetch & ~has_mispredict & ~exter_pc_en;

endmodule

/* fetch_top.sv */
module fetch_top (
    input  logic                                                clk,
    input  logic                                                rst_n,
    input  logic                                                stall_fetch,
    input  logic                                                has_mispredict,
    input  fetch_pkg::pc_t                                      pc_recovery,
    input  logic                                                exter_pc_en,
    input  fetch_pkg::pc_t                                      exter_pc,
    input  logic                                                resolve_valid,
    input  logic                                                resolve_slot,
    input  logic                                                resolve_taken,
    output logic                                                fetch_valid,
    output logic [fetch_pkg::FETCH_WIDTH*fetch_pkg::PC_W-1:0]   pc_to_dec,
    output logic [fetch_pkg::FETCH_WIDTH*fetch_pkg::INST_W-1:0] inst_to_dec,
    output logic [fetch_pkg::FETCH_WIDTH-1:0]                   slot_valid,
    output logic [fetch_pkg::FETCH_WIDTH-1:0]                   pred_result_to_dec,
    output logic [fetch_pkg::MAX_BRANCH*fetch_pkg::PC_W-1:0]    recv_pc_to_dec
);
    import fetch_pkg::*;

    pc_t                    pc;
    inst_t                  inst0, inst1, inst2, inst3;
    logic [FETCH_WIDTH-1:0] is_branch, is_jump, branch_num;
    slot_t                  cut_slot;
    logic                   redirect_taken;
    logic                   pred0, pred1;
    pc_t                    redirect_pc, recv_pc0, recv_pc1;

    pc_gen u_pc_gen (
        .clk(clk), .rst_n(rst_n),
        .stall_fetch(stall_fetch),
        .has_mispredict(has_mispredict), .pc_recovery(pc_recovery),
        .exter_pc_en(exter_pc_en), .exter_pc(exter_pc),
        .redirect_taken(redirect_taken), .redirect_pc(redirect_pc),
        .cut_slot(cut_slot),
        .pc(pc), .fetch_valid(fetch_valid)
    );

    instr_mem u_instr_mem (
        .pc(pc),
        .inst0(inst0), .inst1(inst1), .inst2(inst2), .inst3(inst3)
    );

    bundle_classifier u_classifier (
        .inst0(inst0), .inst1(inst1), .inst2(inst2), .inst3(inst3),
        .pred0(pred0), .pred1(pred1),
        .is_branch(is_branch), .is_jump(is_jump), .branch_num(branch_num),
        .slot_valid(slot_valid), .pred_taken(pred_result_to_dec),
        .cut_slot(cut_slot), .redirect_taken(redirect_taken)
    );

    branch_predictor u_predictor (
        .clk(clk), .rst_n(rst_n),
        .resolve_valid(resolve_valid), .resolve_slot(resolve_slot),
        .resolve_taken(resolve_taken),
        .pred0(pred0), .pred1(pred1)
    );

    target_calc u_target_calc (
        .pc(pc),
        .inst0(inst0), .inst1(inst1), .inst2(inst2), .inst3(inst3),
        .is_branch(is_branch), .is_jump(is_jump), .branch_num(branch_num),
        .pred_taken(pred_result_to_dec), .cut_slot(cut_slot),
        .redirect_pc(redirect_pc), .recv_pc0(recv_pc0), .recv_pc1(recv_pc1)
    );

    ////////////////////
    // decode packing, slot 0 low
    ////////////////////
    for (genvar g = 0; g < FETCH_WIDTH; g++) begin : g_pc_pack
        assign pc_to_dec[g*PC_W +: PC_W] = pc + pc_t'(g);
    end

    assign inst_to_dec    = {inst3, inst2, inst1, inst0};
    assign recv_pc_to_dec = {recv_pc1, recv_pc0};  // second branch high

endmodule

/* fetch_properties.sv */
module fetch_properties (
    input logic           clk,
    input logic           rst_n,
    input logic           stall_fetch,
    input logic           has_mispredict,
    input logic           exter_pc_en,
    input fetch_pkg::pc_t pc,
    input logic           fetch_valid,
    input logic           slot0_valid     // from the top, not local to pc_gen
);
    int unsigned fail_count = 0;  // summed into the final report

    // a stall with no override freezes the pc
    stall_holds_pc: assert property (@(posedge clk) disable iff (!rst_n)
        stall_fetch && !has_mispredict && !exter_pc_en |=> pc == $past(pc))
        else begin
            fail_count++;
            $error("pc moved during a lone stall");
        end

    // first edge after release, start still low
    no_fetch_after_reset: assert property (@(posedge clk)
        !$past(rst_n) && rst_n |-> !fetch_valid)
        else begin
            fail_count++;
            $error("fetch_valid high in the cycle after reset");
        end

    slot0_valid_on_fetch: assert property (@(posedge clk) disable iff (!rst_n)
        fetch_valid |-> slot0_valid)
        else begin
            fail_count++;
            $error("slot 0 invalid while fetch_valid is high");
        end

endmodule

/* tb_clock_gen.sv */
module tb_clock_gen (
    output logic clk
);
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // period 4
    end

endmodule

/* tb_fetch.sv */
module tb_fetch;
    import fetch_pkg::*;

    localparam int N_CYCLES = 2000;
    localparam int PERIOD   = 4;

    logic        clk, rst_n;
    logic        stall_fetch, has_mispredict, exter_pc_en;
    pc_t         pc_recovery, exter_pc;
    logic        resolve_valid, resolve_slot, resolve_taken;
    logic        fetch_valid;
    logic [63:0] pc_to_dec, inst_to_dec;
    logic [3:0]  slot_valid, pred_result_to_dec;
    logic [31:0] recv_pc_to_dec;

    inst_t       rom [IMEM_DEPTH];       // model copy of the program
    pc_t         m_pc;
    logic        m_start;
    ctr_t        m_ctr [MAX_BRANCH];
    logic [31:0] lfsr = 32'habdc_df44;
    int          n_checks = 0;
    int          n_errors = 0;

    tb_clock_gen u_clk (.clk(clk));

    fetch_top dut (.*);

    bind pc_gen fetch_properties u_props (
        .clk(clk), .rst_n(rst_n), .stall_fetch(stall_fetch),
        .has_mispredict(has_mispredict), .exter_pc_en(exter_pc_en),
        .pc(pc), .fetch_valid(fetch_valid),
        .slot0_valid(tb_fetch.dut.slot_valid[0])
    );

    ////////////////////
    // helpers
    ////////////////////
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // taps 32 22 2 1
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};  // one step per bit
        end
    endtask

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("ERR %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    // expected bundle from model pc and counters; e_flow is the pc if nothing overrides
    task automatic model_bundle(output logic [63:0] e_pc, output logic [63:0] e_inst,
                                output logic [3:0] e_valid, output logic [3:0] e_pred,
                                output logic [31:0] e_recv, output pc_t e_flow);
        pc_t   spc, tgt, rcv;
        inst_t w;
        logic  seen, done, p;
        seen   = 1'b0;
        done   = 1'b0;
        e_recv = '0;
        e_pred = '0;
        e_flow = m_pc + 16'd4;  // full bundle
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            spc                = m_pc + pc_t'(i);
            w                  = rom[int'(spc) % IMEM_DEPTH];
            e_pc[i*16 +: 16]   = spc;
            e_inst[i*16 +: 16] = w;
            e_valid[i]         = !done;
            if (!done && w[15:12] == OP_BRANCH) begin
                p         = seen ? m_ctr[1][1] : m_ctr[0][1];
                tgt       = spc + 16'd1 + {{8{w[7]}}, w[7:0]};
                rcv       = p ? spc + 16'd1 : tgt;  // the other path
                e_pred[i] = p;
                if (seen) e_recv[31:16] = rcv;
                else e_recv[15:0] = rcv;
                if (p || seen) begin
                    done   = 1'b1;
                    e_flow = p ? tgt : spc + 16'd1;
                end
                seen = 1'b1;
            end else if (!done && w[15:12] == OP_JUMP) begin
                done   = 1'b1;
                e_flow = {spc[15:12], w[11:0]};  // page of the jump slot
            end
        end
    endtask

    ////////////////////
    // stimulus and checks
    ////////////////////
    initial begin : stimulus
        logic [63:0] e_pc, e_inst;
        logic [3:0]  e_valid, e_pred;
        logic [31:0] e_recv, r;
        pc_t         e_flow;
        logic        e_fv;
        rst_n          = 1'b0;
        stall_fetch    = 1'b0;
        has_mispredict = 1'b0;
        pc_recovery    = '0;
        exter_pc_en    = 1'b0;
        exter_pc       = '0;
        resolve_valid  = 1'b0;
        resolve_slot   = 1'b0;
        resolve_taken  = 1'b0;
        $readmemh("program.hex", rom);
        m_pc     = '0;
        m_start  = 1'b0;
        m_ctr[0] = CTR_WEAK_NT;
        m_ctr[1] = CTR_WEAK_NT;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        for (int c = 0; c < N_CYCLES; c++) begin
            draw_bits(16, r);
            stall_fetch    = (r[2:0] == 0);    // ~1 in 8
            has_mispredict = (r[6:3] == 0);    // ~1 in 16
            exter_pc_en    = (r[11:7] == 0);   // ~1 in 32
            resolve_valid  = (r[13:12] == 0);  // ~1 in 4
            resolve_slot   = r[14];
            resolve_taken  = r[15];
            draw_bits(16, r);
            pc_recovery    = r[15:0];
            draw_bits(16, r);
            exter_pc       = r[15:0];
            #1;  // settled, one unit before the rising edge
            model_bundle(e_pc, e_inst, e_valid, e_pred, e_recv, e_flow);
            e_fv = m_start && !stall_fetch && !has_mispredict && !exter_pc_en;
            check("fetch_valid", 64'(fetch_valid), 64'(e_fv));
            check("pc_to_dec", pc_to_dec, e_pc);
            check("inst_to_dec", inst_to_dec, e_inst);
            check("slot_valid", 64'(slot_valid), 64'(e_valid));
            check("pred_result_to_dec", 64'(pred_result_to_dec), 64'(e_pred));
            check("recv_pc_to_dec", 64'(recv_pc_to_dec), 64'(e_recv));
            // model state at the coming edge
            if (exter_pc_en) m_pc = exter_pc;
            else if (has_mispredict) m_pc = pc_recovery;
            else if (!stall_fetch && m_start) m_pc = e_flow;
            m_start = 1'b1;
            if (resolve_valid && resolve_taken && m_ctr[resolve_slot] != CTR_STRONG_T) begin
                m_ctr[resolve_slot] = m_ctr[resolve_slot] + 2'd1;
            end else if (resolve_valid && !resolve_taken
                         && m_ctr[resolve_slot] != CTR_STRONG_NT) begin
                m_ctr[resolve_slot] = m_ctr[resolve_slot] - 2'd1;
            end
            @(negedge clk);
        end
        $display("checks %0d, errors %0d, assertion failures %0d",
                 n_checks, n_errors, dut.u_pc_gen.u_props.fail_count);
        if (n_errors == 0 && dut.u_pc_gen.u_props.fail_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin : watchdog
        #(4 * N_CYCLES * PERIOD);
        $display("timeout, the stimulus loop did not complete");
        $display("Finished with errors");
        $finish;
    end

endmodule

/* program.hex */
// one 16-bit instruction per line, word 0 to 31; Bxxx branch, Cxxx jump
1234
2001
B003
3ABC
C00A
4111
B0FE
B002
5000
6001
7002
C014
B005
8003
9004
C01E
A005
B0F0
0006
1007
B001
B003
2008
3009
C003
400A
B0E8
500B
D00C
E00D
C01A
F00E

/* src.f */
fetch_pkg.sv
instr_mem.sv
bundle_classifier.sv
branch_predictor.sv
target_calc.sv
pc_gen.sv
fetch_top.sv
fetch_properties.sv
tb_clock_gen.sv
tb_fetch.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert --top-module tb_fetch -f src.f -o tb_fetch_sim \
    && ./obj_dir/tb_fetch_sim +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log 2>/dev/null
! grep -qs "Finished with errors" sim.log && grep -qs "Finished with no errors" sim.log || exit 1
